//--- Makefile
# Verilator build and run for the bgpu_board subsystem

VERILATOR   ?= verilator
TOP         ?= bgpu_board_tb
FILELIST    ?= bgpu_board.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 100
VFLAGS      ?= --binary --timing --assert
FAIL_MSG    ?= Simulation finished: FAIL
PASS_MSG    ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Run ended early, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bgpu_board.f
hdl/bgpu_cfg_pkg.sv
hdl/bgpu_bus_pkg.sv
hdl/bgpu_rst_sync.sv
hdl/bgpu_host_decoder.sv
hdl/bgpu_mem_init.sv
hdl/bgpu_scratch_mem.sv
hdl/bgpu_status_out.sv
hdl/bgpu_board_top.sv
tb/bgpu_board_properties.sv
tb/bgpu_board_tb.sv

//--- hdl/bgpu_board_top.sv
/*
 * BGPU board subsystem
 * Reset and lock handling, host command decoding, calibration wait,
 * scratch memory and status outputs on a single clock
 */
module bgpu_board_top (
    // Clock and external reset
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    // External PLL lock level
    input  logic                            pll_locked_i,

    // Host command port
    input  logic                            host_valid_i,
    input  bgpu_bus_pkg::host_word_u        host_word_i,

    // Status LEDs
    output logic                            status_pll_locked_no, // PLL locked
    output logic                            status_running_no,
    output logic                            status_init_done_no,

    // Host response
    output logic                            rsp_valid_o,
    output logic [bgpu_cfg_pkg::DATA_W-1:0] rsp_data_o,
    output logic                            rejected_o
);
    import bgpu_bus_pkg::*;

    // System reset after synchronisation
    logic sys_rst_n;
    // Calibration finished
    logic init_done;

    mem_req_t      mem_req;
    mem_rsp_t      mem_rsp;
    logic          rejected;
    board_status_t status;

    // ####################################################################
    // Reset
    // ####################################################################

    bgpu_rst_sync i_rst_sync (
        .clk_i       ( clk_i        ),
        .rst_n_i     ( rst_n_i      ),
        .pll_locked_i( pll_locked_i ),
        .sys_rst_n_o ( sys_rst_n    )
    );

    bgpu_mem_init i_mem_init (
        .clk_i      ( clk_i     ),
        .sys_rst_n_i( sys_rst_n ),
        .init_done_o( init_done )
    );

    // ####################################################################
    // Host path and memory
    // ####################################################################

    bgpu_host_decoder i_host_decoder (
        .clk_i       ( clk_i        ),
        .sys_rst_n_i ( sys_rst_n    ),
        .init_done_i ( init_done    ),
        .host_valid_i( host_valid_i ),
        .host_word_i ( host_word_i  ),
        .mem_req_o   ( mem_req      ),
        .rejected_o  ( rejected     )
    );

    bgpu_scratch_mem i_scratch_mem (
        .clk_i      ( clk_i     ),
        .sys_rst_n_i( sys_rst_n ),
        .mem_req_i  ( mem_req   ),
        .mem_rsp_o  ( mem_rsp   )
    );

    // Lock level straight from the pin
    assign status = '{pll_locked: pll_locked_i, running: sys_rst_n, init_done: init_done};

    bgpu_status_out i_status_out (
        .clk_i               ( clk_i                ),
        .sys_rst_n_i         ( sys_rst_n            ),
        .status_i            ( status               ),
        .mem_rsp_i           ( mem_rsp              ),
        .rejected_i          ( rejected             ),
        .status_pll_locked_no( status_pll_locked_no ),
        .status_running_no   ( status_running_no    ),
        .status_init_done_no ( status_init_done_no  ),
        .rsp_valid_o         ( rsp_valid_o          ),
        .rsp_data_o          ( rsp_data_o           ),
        .rejected_o          ( rejected_o           )
    );

endmodule : bgpu_board_top

//--- hdl/bgpu_bus_pkg.sv
/*
 * BGPU board bus types
 * Host command encoding, the host word union, the scratch memory
 * request and response structs and the board status flags
 */
package bgpu_bus_pkg;

    // ####################################################################
    // Host port
    // ####################################################################

    // Host opcodes, everything else is ignored
    typedef enum logic [bgpu_cfg_pkg::OPC_W-1:0] {
        NOP   = 4'h0,
        READ  = 4'h1,
        WRITE = 4'h2
    } host_opcode_e;

    // Command view of a host word
    typedef struct packed {
        host_opcode_e                                                   opcode;
        logic [bgpu_cfg_pkg::DATA_W-bgpu_cfg_pkg::OPC_W-bgpu_cfg_pkg::MEM_ADDR_W-1:0] rsvd;
        logic [bgpu_cfg_pkg::MEM_ADDR_W-1:0]                           addr;
    } host_cmd_t;

    // Same host word, either a command or write data
    typedef union packed {
        host_cmd_t                       cmd;
        logic [bgpu_cfg_pkg::DATA_W-1:0] raw;
    } host_word_u;

    // ####################################################################
    // Scratch memory port
    // ####################################################################

    typedef struct packed {
        logic                                valid;
        logic                                write;
        logic [bgpu_cfg_pkg::MEM_ADDR_W-1:0] addr;
        logic [bgpu_cfg_pkg::DATA_W-1:0]     wdata;
    } mem_req_t;

    typedef struct packed {
        logic                            valid;
        logic [bgpu_cfg_pkg::DATA_W-1:0] rdata;
    } mem_rsp_t;

    // Board status, active high here, LEDs invert it
    typedef struct packed {
        logic pll_locked;
        logic running;
        logic init_done;
    } board_status_t;

endpackage : bgpu_bus_pkg

//--- hdl/bgpu_cfg_pkg.sv
/*
 * BGPU board configuration
 * Sizing and timing constants for the board subsystem: reset chain
 * depth, calibration wait, scratch memory geometry and host word fields
 */
package bgpu_cfg_pkg;

    // ####################################################################
    // Reset and init timing
    // ####################################################################

    // Depth of the reset release chain
    localparam int unsigned NUM_RST_REGS = 4;
    // Calibration wait after system reset release
    localparam int unsigned INIT_CYCLES  = 64;
    // Counter width for the calibration wait
    localparam int unsigned INIT_CNT_W   = $clog2(INIT_CYCLES);

    // ####################################################################
    // Memory and host word sizing
    // ####################################################################

    // Scratch memory address width, 256 words
    localparam int unsigned MEM_ADDR_W = 8;
    localparam int unsigned MEM_DEPTH  = 2 ** MEM_ADDR_W;
    // Data word width
    localparam int unsigned DATA_W     = 32;
    // Host opcode width
    localparam int unsigned OPC_W      = 4;

endpackage : bgpu_cfg_pkg

//--- hdl/bgpu_host_decoder.sv
/*
 * BGPU host word decoder
 * Turns strobed host words into scratch memory requests. A WRITE
 * command arms the decoder for one data word. Commands before init
 * done are rejected
 */
module bgpu_host_decoder (
    input  logic                    clk_i,
    input  logic                    sys_rst_n_i,

    // Calibration finished
    input  logic                    init_done_i,

    // Host command port
    input  logic                    host_valid_i,
    input  bgpu_bus_pkg::host_word_u host_word_i,

    // Memory request and reject pulse
    output bgpu_bus_pkg::mem_req_t  mem_req_o,
    output logic                    rejected_o
);
    import bgpu_cfg_pkg::*;
    import bgpu_bus_pkg::*;

    // Waiting for write data
    logic armed_q;
    // Address latched from the WRITE command
    logic [MEM_ADDR_W-1:0] waddr_q;

    logic req_valid_q;
    logic reject_q;

    // Request payload
    logic                  req_write_q;
    logic [MEM_ADDR_W-1:0] req_addr_q;
    logic [DATA_W-1:0]     req_wdata_q;

    // Command word that carries a known opcode
    logic cmd_known;

    assign cmd_known = !armed_q &&
        ((host_word_i.cmd.opcode == READ) || (host_word_i.cmd.opcode == WRITE));

    // ####################################################################
    // Control state
    // ####################################################################

    always_ff @(posedge clk_i) begin
        if (!sys_rst_n_i) begin
            armed_q     <= 1'b0;
            req_valid_q <= 1'b0;
            reject_q    <= 1'b0;
        end else begin
            // Pulses by default
            req_valid_q <= 1'b0;
            reject_q    <= 1'b0;
            if (host_valid_i && armed_q) begin
                // Data word, never rejected
                armed_q     <= 1'b0;
                req_valid_q <= 1'b1;
            end else if (host_valid_i && cmd_known) begin
                if (!init_done_i) begin
                    reject_q <= 1'b1;
                end else if (host_word_i.cmd.opcode == READ) begin
                    req_valid_q <= 1'b1;
                end else begin
                    armed_q <= 1'b1;
                end
            end
        end
    end

    // ####################################################################
    // Payload
    // ####################################################################

    always_ff @(posedge clk_i) begin
        if (host_valid_i && armed_q) begin
            req_write_q <= 1'b1;
            req_addr_q  <= waddr_q;
            req_wdata_q <= host_word_i.raw;
        end else if (host_valid_i && !armed_q) begin
            req_write_q <= 1'b0;
            req_addr_q  <= host_word_i.cmd.addr;
            // Write address held until data arrives
            waddr_q     <= host_word_i.cmd.addr;
        end
    end

    assign mem_req_o = '{valid: req_valid_q, write: req_write_q,
                         addr: req_addr_q, wdata: req_wdata_q};
    assign rejected_o = reject_q;

endmodule : bgpu_host_decoder

//--- hdl/bgpu_mem_init.sv
/*
 * BGPU memory init sequencer
 * Stands in for DDR calibration: waits a fixed number of cycles
 * after system reset release, then holds init done high
 */
module bgpu_mem_init (
    input  logic clk_i,
    input  logic sys_rst_n_i,

    // Calibration complete
    output logic init_done_o
);
    import bgpu_cfg_pkg::*;

    logic [INIT_CNT_W-1:0] cnt_q;
    logic                  done_q;

    // ####################################################################
    // Calibration wait
    // ####################################################################

    always_ff @(posedge clk_i) begin
        if (!sys_rst_n_i) begin
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else if (!done_q) begin
            // Last count sets done, counter then parks
            if (cnt_q == INIT_CNT_W'(INIT_CYCLES - 1)) begin
                done_q <= 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // Sticky until next system reset
    assign init_done_o = done_q;

endmodule : bgpu_mem_init

//--- hdl/bgpu_rst_sync.sv
/*
 * BGPU reset synchroniser
 * Joins the external reset with PLL lock and releases the system
 * reset only after the request has been stable through the chain
 */
module bgpu_rst_sync (
    // Clock and external reset
    input  logic clk_i,
    input  logic rst_n_i,

    // External PLL lock level
    input  logic pll_locked_i,

    // Synchronised system reset
    output logic sys_rst_n_o
);
    import bgpu_cfg_pkg::*;

    // Reset requested by external reset or missing lock
    logic rst_req_n;

    // Release chain, bit 0 fills first
    logic [NUM_RST_REGS-1:0] sync_q;

    assign rst_req_n = rst_n_i && pll_locked_i;

    // ####################################################################
    // Release chain
    // ####################################################################

    always_ff @(posedge clk_i) begin
        if (!rst_req_n) begin
            // Assert at the next edge
            sync_q <= '0;
        end else begin
            // Shift ones in while the request stays high
            sync_q <= {sync_q[NUM_RST_REGS-2:0], 1'b1};
        end
    end

    // Last stage drives the system reset
    assign sys_rst_n_o = sync_q[NUM_RST_REGS-1];

endmodule : bgpu_rst_sync

//--- hdl/bgpu_scratch_mem.sv
/*
 * BGPU scratch memory
 * On-chip word memory in place of the DDR3 controller. Accepts
 * one request per cycle, returns read data one cycle after a read
 */
module bgpu_scratch_mem (
    input  logic                   clk_i,
    input  logic                   sys_rst_n_i,

    // Request from the host decoder
    input  bgpu_bus_pkg::mem_req_t mem_req_i,

    // Registered read response
    output bgpu_bus_pkg::mem_rsp_t mem_rsp_o
);
    import bgpu_cfg_pkg::*;

    // Storage, contents undefined until written
    logic [DATA_W-1:0] mem_q [MEM_DEPTH];

    // Read and write strobes
    logic rd_en;
    logic wr_en;

    logic              rsp_valid_q;
    logic [DATA_W-1:0] rdata_q;

    assign rd_en = mem_req_i.valid && !mem_req_i.write;
    assign wr_en = mem_req_i.valid && mem_req_i.write;

    // ####################################################################
    // Write port
    // ####################################################################

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[mem_req_i.addr] <= mem_req_i.wdata;
        end
    end

    // ####################################################################
    // Read port
    // ####################################################################

    // Response valid one cycle after the read
    always_ff @(posedge clk_i) begin
        if (!sys_rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= rd_en;
        end
    end

    // Read data only moves on a read
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_q <= mem_q[mem_req_i.addr];
        end
    end

    assign mem_rsp_o = '{valid: rsp_valid_q, rdata: rdata_q};

endmodule : bgpu_scratch_mem

//--- hdl/bgpu_status_out.sv
/*
 * BGPU status outputs
 * Active-low status LEDs, read response with held data, reject pulse
 */
module bgpu_status_out (
    input  logic                                clk_i,
    input  logic                                sys_rst_n_i,

    // Board status and results
    input  bgpu_bus_pkg::board_status_t         status_i,
    input  bgpu_bus_pkg::mem_rsp_t              mem_rsp_i,
    input  logic                                rejected_i,

    // Status LEDs, active low
    output logic                                status_pll_locked_no,
    output logic                                status_running_no,
    output logic                                status_init_done_no,

    // Host response
    output logic                                rsp_valid_o,
    output logic [bgpu_cfg_pkg::DATA_W-1:0]     rsp_data_o,
    output logic                                rejected_o
);
    import bgpu_cfg_pkg::*;

    // Data of the last response
    logic [DATA_W-1:0] data_q;

    // LEDs light on a low level
    assign status_pll_locked_no = !status_i.pll_locked;
    assign status_running_no    = !status_i.running;
    assign status_init_done_no  = !status_i.init_done;

    // ####################################################################
    // Response hold
    // ####################################################################

    always_ff @(posedge clk_i) begin
        if (!sys_rst_n_i) begin
            data_q <= '0;
        end else if (mem_rsp_i.valid) begin
            data_q <= mem_rsp_i.rdata;
        end
    end

    // Fresh data in the valid cycle, held value otherwise
    assign rsp_data_o  = mem_rsp_i.valid ? mem_rsp_i.rdata : data_q;
    assign rsp_valid_o = mem_rsp_i.valid;
    assign rejected_o  = rejected_i;

endmodule : bgpu_status_out

//--- tb/bgpu_board_properties.sv
/*
 * BGPU board properties
 * Concurrent checks on reject timing, read response origin and
 * reset release, bound into the board top level
 */
module bgpu_board_properties (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    pll_locked_i,
    input  logic                    host_valid_i,
    input  bgpu_bus_pkg::host_word_u host_word_i,
    input  logic                    init_done_i,
    input  logic                    rejected_i,
    input  logic                    rsp_valid_i,
    input  logic                    status_running_n_i
);
    import bgpu_cfg_pkg::*;
    import bgpu_bus_pkg::*;

    // Failed assertions, read by the testbench summary
    int unsigned fail_cnt = 0;
    // Consecutive cycles with the reset request high
    int unsigned req_cnt = 0;

    logic rst_req;
    logic read_strobe;

    assign rst_req     = rst_n_i && pll_locked_i;
    assign read_strobe = host_valid_i && (host_word_i.cmd.opcode == READ);

    always @(posedge clk_i) begin
        if (!rst_req) begin
            req_cnt <= 0;
        end else if (req_cnt < NUM_RST_REGS) begin
            req_cnt <= req_cnt + 1;
        end
    end

    // ####################################################################
    // Assertions
    // ####################################################################

    // Reject only for a command seen before init done
    reject_before_init: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rejected_i |-> !$past(init_done_i))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("rejected_o raised with init done high");
        end

    // Every response comes from a read strobe two cycles back
    rsp_from_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i |-> $past(read_strobe, 2))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("rsp_valid_o without a read strobe two cycles earlier");
        end

    // Running LED dark until the chain has filled
    running_held_off: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (req_cnt < NUM_RST_REGS) |-> status_running_n_i)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("running LED on before reset chain filled");
        end

endmodule : bgpu_board_properties

bind bgpu_board_top bgpu_board_properties i_props (
    .clk_i             ( clk_i             ),
    .rst_n_i           ( rst_n_i           ),
    .pll_locked_i      ( pll_locked_i      ),
    .host_valid_i      ( host_valid_i      ),
    .host_word_i       ( host_word_i       ),
    .init_done_i       ( init_done         ),
    .rejected_i        ( rejected_o        ),
    .rsp_valid_i       ( rsp_valid_o       ),
    .status_running_n_i( status_running_no )
);

//--- tb/bgpu_board_tb.sv
/*
 * BGPU board testbench
 * LCG host traffic against a reference model of the reset, init,
 * decoder and scratch memory rules, one line per test
 */
module bgpu_board_tb;
    import bgpu_cfg_pkg::*;
    import bgpu_bus_pkg::*;

    localparam int unsigned RST_CYCLES  = 5;
    localparam int unsigned TRAFFIC_LEN = 160;
    localparam int unsigned BURST_LEN   = 8;
    localparam int unsigned IGNORE_LEN  = 30;
    localparam int unsigned LOCK_DROP   = 3;
    localparam int unsigned EARLY_LEN   = 40;
    localparam int unsigned TAIL_LEN    = 24;
    // Two full reset releases plus every test body
    localparam int unsigned RUN_CYCLES  = RST_CYCLES + 2 * (NUM_RST_REGS + INIT_CYCLES)
        + TRAFFIC_LEN + TAIL_LEN + 2 * BURST_LEN + IGNORE_LEN + LOCK_DROP + EARLY_LEN + 8;
    localparam int unsigned TIMEOUT_CYCLES = RUN_CYCLES + 200;

    logic              clk_i;
    logic              rst_n_i;
    logic              pll_locked_i;
    logic              host_valid_i;
    host_word_u        host_word_i;
    logic              status_pll_locked_no;
    logic              status_running_no;
    logic              status_init_done_no;
    logic              rsp_valid_o;
    logic [DATA_W-1:0] rsp_data_o;
    logic              rejected_o;

    // Reference model
    logic [DATA_W-1:0]     mem_m [MEM_DEPTH];
    bit                    written_m [MEM_DEPTH];
    logic [MEM_ADDR_W-1:0] wr_addrs [$];
    int unsigned           up_cnt;
    int unsigned           init_cnt;
    bit                    armed_m;
    logic [MEM_ADDR_W-1:0] waddr_m;
    bit                    pll_m;
    // Data held on the response port between responses
    logic [DATA_W-1:0]     hold_m;
    // Expected outputs, stage 0 is checked next
    bit                    exp_rej;
    bit                    exp_v0;
    bit                    exp_v1;
    logic [DATA_W-1:0]     exp_d0;
    logic [DATA_W-1:0]     exp_d1;

    bit                    rst_drv;
    bit                    pll_drv;
    logic [31:0]           lcg_state = 32'd63;
    int unsigned           errors = 0;
    int unsigned           test_base = 0;
    int unsigned           n_tests = 0;
    int unsigned           cyc_cnt = 0;

    bgpu_board_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, DUT never reached the expected state", cyc_cnt);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [MEM_ADDR_W-1:0] pick_addr();
        return wr_addrs[lcg_next() % wr_addrs.size()];
    endfunction

    // ####################################################################
    // Compare tasks
    // ####################################################################

    task automatic check_status(input board_status_t exp);
        board_status_t got;
        got.pll_locked = !status_pll_locked_no;
        got.running    = !status_running_no;
        got.init_done  = !status_init_done_no;
        if (got !== exp) begin
            errors++;
            $display("FAIL status LEDs: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_rsp(input logic exp_valid, input logic [DATA_W-1:0] exp_data);
        if (rsp_valid_o !== exp_valid) begin
            errors++;
            $display("FAIL rsp_valid_o: got %h expected %h", rsp_valid_o, exp_valid);
        end else if (rsp_data_o !== exp_data) begin
            errors++;
            $display("FAIL rsp_data_o: got %h expected %h", rsp_data_o, exp_data);
        end
    endtask

    task automatic check_reject(input bit exp);
        if (rejected_o !== exp) begin
            errors++;
            $display("FAIL rejected_o: got %h expected %h", rejected_o, exp);
        end
    endtask

    // ####################################################################
    // One clock: check, advance model, drive
    // ####################################################################

    task automatic step(input logic valid, input host_word_u word);
        bit                old_run;
        bit                old_init;
        bit                new_v;
        bit                new_rej;
        logic [DATA_W-1:0] new_d;
        board_status_t     exp_st;
        old_run  = (up_cnt >= NUM_RST_REGS);
        old_init = (init_cnt >= INIT_CYCLES);
        exp_st.pll_locked = pll_m;
        exp_st.running    = old_run;
        exp_st.init_done  = old_init;
        check_status(exp_st);
        check_reject(exp_rej);
        check_rsp(exp_v0, exp_v0 ? exp_d0 : hold_m);
        new_v   = 1'b0;
        new_rej = 1'b0;
        new_d   = '0;
        // Decoder held in reset while not running
        if (!old_run) begin
            armed_m = 1'b0;
        end else if (valid && armed_m) begin
            mem_m[waddr_m] = word.raw;
            if (!written_m[waddr_m]) begin
                written_m[waddr_m] = 1'b1;
                wr_addrs.push_back(waddr_m);
            end
            armed_m = 1'b0;
        end else if (valid && ((word.cmd.opcode == READ) || (word.cmd.opcode == WRITE))) begin
            if (!old_init) begin
                new_rej = 1'b1;
            end else if (word.cmd.opcode == READ) begin
                new_v = 1'b1;
                new_d = mem_m[word.cmd.addr];
            end else begin
                armed_m = 1'b1;
                waddr_m = word.cmd.addr;
            end
        end
        // Output hold register takes the response seen this cycle
        if (!old_run) begin
            hold_m = '0;
        end else if (exp_v0) begin
            hold_m = exp_d0;
        end
        exp_v0  = old_run ? exp_v1 : 1'b0;
        exp_d0  = exp_d1;
        exp_v1  = new_v;
        exp_d1  = new_d;
        exp_rej = new_rej;
        // Calibration counts only while running
        if (!old_run) begin
            init_cnt = 0;
        end else if (init_cnt < INIT_CYCLES) begin
            init_cnt++;
        end
        if (!(rst_drv && pll_drv)) begin
            up_cnt = 0;
        end else if (up_cnt < NUM_RST_REGS) begin
            up_cnt++;
        end
        rst_n_i      = rst_drv;
        pll_locked_i = pll_drv;
        host_valid_i = valid;
        host_word_i  = word;
        pll_m        = pll_drv;
        @(negedge clk_i);
    endtask

    task automatic idle(input int unsigned n);
        repeat (n) step(1'b0, '0);
    endtask

    task automatic send_cmd(input logic [OPC_W-1:0] op, input logic [MEM_ADDR_W-1:0] addr);
        host_word_u  w;
        logic [31:0] r;
        r     = lcg_next();
        w.raw = {op, r[DATA_W-OPC_W-MEM_ADDR_W-1:0], addr};
        step(1'b1, w);
    endtask

    task automatic send_data(input logic [DATA_W-1:0] d);
        host_word_u w;
        w.raw = d;
        step(1'b1, w);
    endtask

    task automatic random_traffic(input int unsigned n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = lcg_next();
            if (r[31:29] == 3'd0) begin
                idle(1);
            end else if (armed_m) begin
                send_data(lcg_next());
            end else if (r[28] && (wr_addrs.size() > 0)) begin
                send_cmd(READ, pick_addr());
            end else begin
                send_cmd(WRITE, r[MEM_ADDR_W-1:0]);
            end
        end
        // Leave the decoder unarmed
        if (armed_m) begin
            send_data(lcg_next());
        end
    endtask

    task automatic read_burst(input int unsigned n);
        repeat (n) send_cmd(READ, pick_addr());
    endtask

    task automatic report_test(input string name);
        $display("test %s: %s, %0d errors", name, (errors == test_base) ? "ok" : "failed",
                 errors - test_base);
        test_base = errors;
        n_tests++;
    endtask

    // ####################################################################
    // Test sequence
    // ####################################################################

    initial begin
        logic [31:0] r;
        logic [OPC_W-1:0] op;
        rst_n_i      = 1'b0;
        pll_locked_i = 1'b1;
        host_valid_i = 1'b0;
        host_word_i  = '0;
        rst_drv  = 1'b0;
        pll_drv  = 1'b1;
        pll_m    = 1'b1;
        up_cnt   = 0;
        init_cnt = 0;
        armed_m  = 1'b0;
        hold_m   = '0;
        exp_rej  = 1'b0;
        exp_v0   = 1'b0;
        exp_v1   = 1'b0;
        exp_d0   = '0;
        exp_d1   = '0;
        // Reset over RST_CYCLES rising edges, then back to the drive edge
        repeat (RST_CYCLES) @(posedge clk_i);
        @(negedge clk_i);

        // Release external reset, model checks LED timing each cycle
        rst_drv = 1'b1;
        idle(NUM_RST_REGS + INIT_CYCLES + 1);
        report_test("reset_release");

        random_traffic(TRAFFIC_LEN);
        read_burst(BURST_LEN);
        report_test("random_traffic");

        for (int i = 0; i < IGNORE_LEN; i++) begin
            r  = lcg_next();
            op = r[31:28];
            if ((op == READ) || (op == WRITE)) begin
                op = op + 4'd8;
            end
            send_cmd(op, r[MEM_ADDR_W-1:0]);
        end
        report_test("ignored_words");

        pll_drv = 1'b0;
        idle(LOCK_DROP);
        pll_drv = 1'b1;
        while (status_running_no) idle(1);
        report_test("lock_loss");

        // Commands inside the calibration wait
        for (int i = 0; i < EARLY_LEN; i++) begin
            r = lcg_next();
            send_cmd(r[0] ? READ : WRITE, r[8 +: MEM_ADDR_W]);
        end
        while (status_init_done_no) idle(1);
        random_traffic(TAIL_LEN);
        read_burst(BURST_LEN);
        report_test("early_commands");

        idle(3);
        $display("Summary: %0d tests, %0d check errors, %0d assertion failures",
                 n_tests, errors, dut_i.i_props.fail_cnt);
        if ((errors == 0) && (dut_i.i_props.fail_cnt == 0)) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : bgpu_board_tb
